// ==== sim.f ====
src/fc_pkg.sv
src/event_fifo.sv
src/irq_timer.sv
src/irq_regs.sv
src/irq_handshake_fsm.sv
src/fc_event_unit.sv
verification/tb_fc_event_unit.sv

// ==== Bender.yml ====
package:
  name: fc_event_unit

sources:
  - src/fc_pkg.sv
  - src/event_fifo.sv
  - src/irq_timer.sv
  - src/irq_regs.sv
  - src/irq_handshake_fsm.sv
  - src/fc_event_unit.sv
  - target: test
    files:
      - verification/tb_fc_event_unit.sv

// ==== verification/tb_fc_event_unit.sv ====
// Table-driven testbench for the fabric controller event unit with a model of the core

`default_nettype none

module tb_fc_event_unit;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned FIFO_DEPTH     = 4;
    localparam int unsigned EVENT_ID_WIDTH = fc_pkg::EVENT_ID_WIDTH_DEF;
    localparam int unsigned RST_CYCLES     = 5;
    localparam int unsigned STEP_CYCLES    = 50;
    localparam int unsigned RESP_TIMEOUT   = 16;
    localparam int unsigned IRQ_TIMEOUT    = 64;
    localparam int unsigned PORT_SETTLE    = 4;

    // Output ports observed by OP_PORT through the address field
    localparam fc_pkg::reg_addr_t PORT_REQ      = 3'd0;
    localparam fc_pkg::reg_addr_t PORT_FETCH    = 3'd1;
    localparam fc_pkg::reg_addr_t PORT_FULLN    = 3'd2;
    localparam fc_pkg::reg_addr_t PORT_NEW_IRQS = 3'd3;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_EVENT,
        OP_PUSH,
        OP_WAIT_IRQ,
        OP_PORT
    } op_e;

    typedef struct packed {
        logic [3:0]        group;
        op_e               kind;
        fc_pkg::reg_addr_t addr;
        fc_pkg::reg_data_t data;
        fc_pkg::reg_data_t expected;
    } step_t;

    logic                      clk = 1'b0;
    logic                      rst;
    fc_pkg::reg_req_t          reg_req;
    fc_pkg::reg_data_t         reg_rdata;
    logic                      reg_rvalid;
    fc_pkg::irq_vec_t          events;
    logic                      fifo_valid;
    logic [EVENT_ID_WIDTH-1:0] fifo_data;
    logic                      fifo_fulln;
    logic                      irq_req;
    fc_pkg::irq_id_t           irq_id;
    logic                      irq_ack;
    fc_pkg::irq_id_t           irq_ack_id;
    logic                      fetch_en_in;
    logic                      fetch_en_out;

    step_t           steps[$];
    fc_pkg::irq_id_t acked_ids[$];
    int unsigned     rise_cycles[$];
    int unsigned     cycle = 0;
    int unsigned     rises = 0;
    int unsigned     irq_seen = 0;
    int unsigned     step_errors = 0;
    int unsigned     pass_count = 0;
    int unsigned     fail_count = 0;
    bit              table_ready = 1'b0;
    integer          seed = 32'hb62b;

    fc_event_unit #(
        .FIFO_DEPTH     ( FIFO_DEPTH     ),
        .EVENT_ID_WIDTH ( EVENT_ID_WIDTH )
    ) fc_event_unit_i (
        .clk_i              ( clk          ),
        .rst_i              ( rst          ),
        .reg_req_i          ( reg_req      ),
        .reg_rdata_o        ( reg_rdata    ),
        .reg_rvalid_o       ( reg_rvalid   ),
        .events_i           ( events       ),
        .event_fifo_valid_i ( fifo_valid   ),
        .event_fifo_data_i  ( fifo_data    ),
        .event_fifo_fulln_o ( fifo_fulln   ),
        .core_irq_req_o     ( irq_req      ),
        .core_irq_id_o      ( irq_id       ),
        .core_irq_ack_i     ( irq_ack      ),
        .core_irq_ack_id_i  ( irq_ack_id   ),
        .fetch_en_i         ( fetch_en_in  ),
        .fetch_en_o         ( fetch_en_out )
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //************************************************************
    // Core model
    //************************************************************

    // Acknowledges each request after 1 to 4 cycles
    initial begin
        int unsigned     delay;
        fc_pkg::irq_id_t id;
        irq_ack    = 1'b0;
        irq_ack_id = '0;
        forever begin
            @(negedge clk);
            if (!rst && irq_req) begin
                id = irq_id;
                rises++;
                rise_cycles.push_back(cycle);
                delay = 1 + ({$random(seed)} % 4);
                repeat (delay) @(posedge clk);
                #2;
                irq_ack    = 1'b1;
                irq_ack_id = id;
                @(posedge clk);
                #2;
                irq_ack = 1'b0;
                acked_ids.push_back(id);
            end
        end
    end

    //************************************************************
    // Stimulus table
    //************************************************************

    function automatic void add_step(input logic [3:0] group, input op_e kind,
                                     input fc_pkg::reg_addr_t addr,
                                     input fc_pkg::reg_data_t data,
                                     input fc_pkg::reg_data_t expected);
        steps.push_back(step_t'{group, kind, addr, data, expected});
    endfunction

    function automatic void load_steps();
        // Reset values and fetch enable
        add_step(1, OP_PORT, PORT_REQ, 0, 0);
        add_step(1, OP_PORT, PORT_FETCH, 0, 0);
        add_step(1, OP_READ, fc_pkg::REG_PENDING, 0, 0);
        add_step(1, OP_WRITE, fc_pkg::REG_FETCH_EN, 1, 0);
        add_step(1, OP_PORT, PORT_FETCH, 0, 1);
        // Two lines at once with the highest going first
        add_step(2, OP_WRITE, fc_pkg::REG_MASK, 32'hFFFF_FFFF, 0);
        add_step(2, OP_EVENT, 0, 32'h0002_0008, 0);
        add_step(2, OP_WAIT_IRQ, 0, 0, 17);
        add_step(2, OP_WAIT_IRQ, 0, 0, 3);
        add_step(2, OP_READ, fc_pkg::REG_PENDING, 0, 0);
        // Masking and software clear
        add_step(3, OP_WRITE, fc_pkg::REG_MASK, 32'hFFFF_FFDF, 0);
        add_step(3, OP_EVENT, 0, 32'h0000_0020, 0);
        add_step(3, OP_PORT, PORT_NEW_IRQS, 0, 0);
        add_step(3, OP_READ, fc_pkg::REG_PENDING, 0, 32'h0000_0020);
        add_step(3, OP_WRITE, fc_pkg::REG_MASK, 32'hFFFF_FFFF, 0);
        add_step(3, OP_WAIT_IRQ, 0, 0, 5);
        add_step(3, OP_WRITE, fc_pkg::REG_MASK, 0, 0);
        add_step(3, OP_EVENT, 0, 32'h0000_0080, 0);
        add_step(3, OP_READ, fc_pkg::REG_PENDING, 0, 32'h0000_0080);
        add_step(3, OP_WRITE, fc_pkg::REG_CLEAR, 32'h0000_0080, 0);
        add_step(3, OP_READ, fc_pkg::REG_PENDING, 0, 0);
        // Queue overflow and head reads
        // The last push finds the queue full and is dropped
        for (int k = 0; k <= FIFO_DEPTH; k++) begin
            add_step(4, OP_PUSH, 0, 32'h11 * (k + 1), 0);
        end
        add_step(4, OP_PORT, PORT_FULLN, 0, 0);
        add_step(4, OP_READ, fc_pkg::REG_PENDING, 0, 32'h0400_0000);
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            add_step(4, OP_READ, fc_pkg::REG_FIFO_HEAD, 0, 32'h11 * (k + 1));
        end
        add_step(4, OP_READ, fc_pkg::REG_FIFO_HEAD, 0, 0);
        add_step(4, OP_PORT, PORT_FULLN, 0, 1);
        add_step(4, OP_READ, fc_pkg::REG_PENDING, 0, 0);
        // Periodic timer with the minimum request spacing as wait data
        add_step(5, OP_WRITE, fc_pkg::REG_MASK, 32'h0000_0400, 0);
        add_step(5, OP_WRITE, fc_pkg::REG_TIMER_CMP, 5, 0);
        add_step(5, OP_WRITE, fc_pkg::REG_TIMER_CTRL, 1, 0);
        add_step(5, OP_WAIT_IRQ, 0, 0, 10);
        add_step(5, OP_WAIT_IRQ, 0, 6, 10);
        add_step(5, OP_WAIT_IRQ, 0, 6, 10);
        add_step(5, OP_WRITE, fc_pkg::REG_TIMER_CTRL, 0, 0);
    endfunction

    //************************************************************
    // Operations
    //************************************************************

    task automatic reg_write(input fc_pkg::reg_addr_t addr, input fc_pkg::reg_data_t data);
        @(posedge clk);
        #2;
        reg_req = '{1'b1, 1'b1, addr, data};
        @(posedge clk);
        #2;
        reg_req = '0;
    endtask

    task automatic reg_read(input fc_pkg::reg_addr_t addr, input fc_pkg::reg_data_t expected);
        int unsigned waited;
        @(posedge clk);
        #2;
        reg_req = '{1'b1, 1'b0, addr, 32'h0};
        @(posedge clk);
        #2;
        reg_req = '0;
        waited  = 0;
        @(negedge clk);
        while (!reg_rvalid && waited < RESP_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!reg_rvalid) begin
            $display("Read of register %0d got no response within %0d cycles", addr, waited);
            step_errors++;
        end else if (reg_rdata !== expected) begin
            $display("** Error at %0t ns: reg_rdata_o expected 0x%h, got 0x%h",
                     $time, expected, reg_rdata);
            step_errors++;
        end
    endtask

    task automatic pulse_events(input fc_pkg::irq_vec_t vec);
        @(posedge clk);
        #2;
        events = vec;
        @(posedge clk);
        #2;
        events = '0;
    endtask

    task automatic push_event(input logic [EVENT_ID_WIDTH-1:0] id);
        @(posedge clk);
        #2;
        fifo_valid = 1'b1;
        fifo_data  = id;
        @(posedge clk);
        #2;
        fifo_valid = 1'b0;
    endtask

    task automatic wait_irq(input fc_pkg::irq_id_t expected, input int unsigned min_gap);
        int unsigned waited;
        int unsigned gap;
        waited = 0;
        while (acked_ids.size() <= irq_seen && waited < IRQ_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (acked_ids.size() <= irq_seen) begin
            $display("No interrupt was acknowledged within %0d cycles", IRQ_TIMEOUT);
            step_errors++;
        end else begin
            if (acked_ids[irq_seen] !== expected) begin
                $display("** Error at %0t ns: core_irq_id_o expected %0d, got %0d",
                         $time, expected, acked_ids[irq_seen]);
                step_errors++;
            end
            if (min_gap != 0 && irq_seen > 0) begin
                gap = rise_cycles[irq_seen] - rise_cycles[irq_seen - 1];
                if (gap < min_gap) begin
                    $display("** Error at %0t ns: core_irq_req_o spacing expected >= %0d, got %0d",
                             $time, min_gap, gap);
                    step_errors++;
                end
            end
            irq_seen++;
        end
    endtask

    task automatic check_port(input fc_pkg::reg_addr_t port, input fc_pkg::reg_data_t expected);
        fc_pkg::reg_data_t actual;
        string             name;
        repeat (PORT_SETTLE) @(posedge clk);
        @(negedge clk);
        case (port)
            PORT_REQ: begin
                name   = "core_irq_req_o";
                actual = {31'b0, irq_req};
            end
            PORT_FETCH: begin
                name   = "fetch_en_o";
                actual = {31'b0, fetch_en_out};
            end
            PORT_FULLN: begin
                name   = "event_fifo_fulln_o";
                actual = {31'b0, fifo_fulln};
            end
            default: begin
                name   = "core_irq_req_o new requests";
                actual = rises - irq_seen;
            end
        endcase
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected 0x%h, got 0x%h",
                     $time, name, expected, actual);
            step_errors++;
        end
    endtask

    task automatic run_step(input step_t s);
        case (s.kind)
            OP_WRITE:    reg_write(s.addr, s.data);
            OP_READ:     reg_read(s.addr, s.expected);
            OP_EVENT:    pulse_events(s.data);
            OP_PUSH:     push_event(s.data[EVENT_ID_WIDTH-1:0]);
            OP_WAIT_IRQ: wait_irq(s.expected[4:0], s.data);
            default:     check_port(s.addr, s.expected);
        endcase
    endtask

    function automatic string op_name(input op_e kind);
        case (kind)
            OP_WRITE:    return "write";
            OP_READ:     return "read";
            OP_EVENT:    return "event pulse";
            OP_PUSH:     return "queue push";
            OP_WAIT_IRQ: return "wait for interrupt";
            default:     return "port check";
        endcase
    endfunction

    //************************************************************
    // Main sequence and watchdog
    //************************************************************

    initial begin
        step_t s;
        $timeformat(-9, 0, "", 0);
        rst         = 1'b1;
        reg_req     = '0;
        events      = '0;
        fifo_valid  = 1'b0;
        fifo_data   = '0;
        fetch_en_in = 1'b1;
        load_steps();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            s           = steps[i];
            step_errors = 0;
            run_step(s);
            if (step_errors == 0) begin
                pass_count++;
                $display("Test %0d (behavior %0d, %s): pass", i, s.group, op_name(s.kind));
            end else begin
                fail_count++;
                $display("Test %0d (behavior %0d, %s): FAIL", i, s.group, op_name(s.kind));
            end
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (RST_CYCLES + steps.size() * STEP_CYCLES) @(posedge clk);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/fc_event_unit.sv ====
// Fabric controller event unit top, joins event queue, timer, register file and core handshake

`default_nettype none

module fc_event_unit #(
    parameter int unsigned FIFO_DEPTH     = 4,
    parameter int unsigned EVENT_ID_WIDTH = fc_pkg::EVENT_ID_WIDTH_DEF
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,

    // Register access
    input  wire fc_pkg::reg_req_t          reg_req_i,
    output      fc_pkg::reg_data_t         reg_rdata_o,
    output      logic                      reg_rvalid_o,

    // Peripheral event pulses
    input  wire fc_pkg::irq_vec_t          events_i,

    // SoC event queue
    input  wire logic                      event_fifo_valid_i,
    input  wire logic [EVENT_ID_WIDTH-1:0] event_fifo_data_i,
    output      logic                      event_fifo_fulln_o,

    // Core interrupt side
    output      logic                      core_irq_req_o,
    output      fc_pkg::irq_id_t           core_irq_id_o,
    input  wire logic                      core_irq_ack_i,
    input  wire fc_pkg::irq_id_t           core_irq_ack_id_i,

    input  wire logic                      fetch_en_i,
    output      logic                      fetch_en_o
);

    logic                      fifo_pop;
    logic [EVENT_ID_WIDTH-1:0] fifo_head;
    logic                      fifo_empty;
    logic                      timer_tick;
    logic                      timer_en;
    fc_pkg::reg_data_t         timer_cmp;
    fc_pkg::irq_vec_t          irq_enabled;
    logic                      irq_clear;
    fc_pkg::irq_id_t           irq_clear_id;

    event_fifo #(
        .FIFO_DEPTH     ( FIFO_DEPTH     ),
        .EVENT_ID_WIDTH ( EVENT_ID_WIDTH )
    ) event_fifo_i (
        .clk_i       ( clk_i              ),
        .rst_i       ( rst_i              ),
        .push_i      ( event_fifo_valid_i ),
        .push_data_i ( event_fifo_data_i  ),
        .pop_i       ( fifo_pop           ),
        .head_o      ( fifo_head          ),
        .empty_o     ( fifo_empty         ),
        .fulln_o     ( event_fifo_fulln_o )
    );

    irq_timer irq_timer_i (
        .clk_i  ( clk_i      ),
        .rst_i  ( rst_i      ),
        .en_i   ( timer_en   ),
        .cmp_i  ( timer_cmp  ),
        .tick_o ( timer_tick )
    );

    irq_regs #(
        .EVENT_ID_WIDTH ( EVENT_ID_WIDTH )
    ) irq_regs_i (
        .clk_i        ( clk_i        ),
        .rst_i        ( rst_i        ),
        .reg_req_i    ( reg_req_i    ),
        .rdata_o      ( reg_rdata_o  ),
        .rvalid_o     ( reg_rvalid_o ),
        .events_i     ( events_i     ),
        .fifo_head_i  ( fifo_head    ),
        .fifo_empty_i ( fifo_empty   ),
        .fifo_pop_o   ( fifo_pop     ),
        .timer_tick_i ( timer_tick   ),
        .timer_en_o   ( timer_en     ),
        .timer_cmp_o  ( timer_cmp    ),
        .clear_i      ( irq_clear    ),
        .clear_id_i   ( irq_clear_id ),
        .enabled_o    ( irq_enabled  ),
        .fetch_en_i   ( fetch_en_i   ),
        .fetch_en_o   ( fetch_en_o   )
    );

    irq_handshake_fsm irq_handshake_fsm_i (
        .clk_i      ( clk_i             ),
        .rst_i      ( rst_i             ),
        .enabled_i  ( irq_enabled       ),
        .ack_i      ( core_irq_ack_i    ),
        .ack_id_i   ( core_irq_ack_id_i ),
        .irq_req_o  ( core_irq_req_o    ),
        .irq_id_o   ( core_irq_id_o     ),
        .clear_o    ( irq_clear         ),
        .clear_id_o ( irq_clear_id      )
    );

endmodule

`default_nettype wire

// ==== src/irq_handshake_fsm.sv ====
// Interrupt request FSM, offers the highest enabled line to the core and clears it on acknowledge

`default_nettype none

module irq_handshake_fsm (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire fc_pkg::irq_vec_t enabled_i,
    input  wire logic             ack_i,
    input  wire fc_pkg::irq_id_t  ack_id_i,
    output      logic             irq_req_o,
    output      fc_pkg::irq_id_t  irq_id_o,
    output      logic             clear_o,
    output      fc_pkg::irq_id_t  clear_id_o
);

    fc_pkg::irq_state_e state_q;
    fc_pkg::irq_state_e state_d;
    fc_pkg::irq_id_t    id_q;
    fc_pkg::irq_id_t    top_id;
    logic               any_enabled;

    // Highest set line wins
    function automatic fc_pkg::irq_id_t highest_set(input fc_pkg::irq_vec_t vec);
        fc_pkg::irq_id_t id;
        id = '0;
        for (int i = 0; i < fc_pkg::NB_IRQ_LINES; i++) begin
            if (vec[i]) begin
                id = fc_pkg::irq_id_t'(i);
            end
        end
        return id;
    endfunction

    assign any_enabled = |enabled_i;
    assign top_id      = highest_set(enabled_i);

    assign irq_req_o  = (state_q == fc_pkg::REQ);
    assign irq_id_o   = id_q;

    // Clear reaches the pending register on the acknowledge edge
    assign clear_o    = (state_q == fc_pkg::REQ) & ack_i;
    assign clear_id_o = ack_id_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fc_pkg::IDLE:  if (any_enabled) state_d = fc_pkg::REQ;
            fc_pkg::REQ:   if (ack_i) state_d = fc_pkg::CLEAR;
            // Pending is already updated here, so a waiting line can go straight out
            fc_pkg::CLEAR: state_d = any_enabled ? fc_pkg::REQ : fc_pkg::IDLE;
            default:       state_d = fc_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= fc_pkg::IDLE;
            id_q    <= '0;
        end else begin
            state_q <= state_d;
            // Id is captured on entry to REQ and held until acknowledged
            if ((state_q != fc_pkg::REQ) && (state_d == fc_pkg::REQ)) begin
                id_q <= top_id;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/irq_regs.sv ====
// Event unit register file with mask, pending update, queue head, timer and fetch enable

`default_nettype none

module irq_regs #(
    parameter int unsigned EVENT_ID_WIDTH = fc_pkg::EVENT_ID_WIDTH_DEF
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,

    input  wire fc_pkg::reg_req_t          reg_req_i,
    output      fc_pkg::reg_data_t         rdata_o,
    output      logic                      rvalid_o,

    input  wire fc_pkg::irq_vec_t          events_i,

    input  wire logic [EVENT_ID_WIDTH-1:0] fifo_head_i,
    input  wire logic                      fifo_empty_i,
    output      logic                      fifo_pop_o,

    input  wire logic                      timer_tick_i,
    output      logic                      timer_en_o,
    output      fc_pkg::reg_data_t         timer_cmp_o,

    input  wire logic                      clear_i,
    input  wire fc_pkg::irq_id_t           clear_id_i,
    output      fc_pkg::irq_vec_t          enabled_o,

    input  wire logic                      fetch_en_i,
    output      logic                      fetch_en_o
);

    fc_pkg::irq_vec_t  mask_q;
    fc_pkg::irq_vec_t  pending_q;
    fc_pkg::irq_vec_t  pending_d;
    fc_pkg::reg_data_t timer_cmp_q;
    logic              timer_en_q;
    logic              fetch_en_q;
    fc_pkg::reg_data_t rdata_q;
    fc_pkg::reg_data_t rdata_d;
    logic              rvalid_q;
    logic              wr_en;
    logic              rd_en;

    assign wr_en = reg_req_i.valid & reg_req_i.write;
    assign rd_en = reg_req_i.valid & ~reg_req_i.write;

    // Reading the queue head consumes it
    assign fifo_pop_o = rd_en && (reg_req_i.addr == fc_pkg::REG_FIFO_HEAD);

    assign enabled_o   = pending_q & mask_q;
    assign timer_en_o  = timer_en_q;
    assign timer_cmp_o = timer_cmp_q;
    assign fetch_en_o  = fetch_en_q & fetch_en_i;
    assign rdata_o     = rdata_q;
    assign rvalid_o    = rvalid_q;

    //************************************************************
    // Pending bit update
    //************************************************************

    always_comb begin
        pending_d = pending_q;

        // Clears first so a new event in the same cycle is not lost
        if (wr_en && (reg_req_i.addr == fc_pkg::REG_CLEAR)) begin
            pending_d = pending_d & ~reg_req_i.wdata;
        end
        if (clear_i) begin
            pending_d[clear_id_i] = 1'b0;
        end

        pending_d = pending_d | events_i;
        if (timer_tick_i) begin
            pending_d[fc_pkg::IRQ_TIMER_LINE] = 1'b1;
        end
        if (wr_en && (reg_req_i.addr == fc_pkg::REG_PENDING)) begin
            pending_d = pending_d | reg_req_i.wdata;
        end

        // Queue line is a level, not a latched event
        pending_d[fc_pkg::IRQ_FIFO_LINE] = ~fifo_empty_i;
    end

    //************************************************************
    // Register writes
    //************************************************************

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mask_q      <= '0;
            pending_q   <= '0;
            timer_cmp_q <= '0;
            timer_en_q  <= 1'b0;
            fetch_en_q  <= 1'b0;
        end else begin
            pending_q <= pending_d;
            if (wr_en) begin
                case (reg_req_i.addr)
                    fc_pkg::REG_MASK:       mask_q      <= reg_req_i.wdata;
                    fc_pkg::REG_TIMER_CMP:  timer_cmp_q <= reg_req_i.wdata;
                    fc_pkg::REG_TIMER_CTRL: timer_en_q  <= reg_req_i.wdata[0];
                    fc_pkg::REG_FETCH_EN:   fetch_en_q  <= reg_req_i.wdata[0];
                    default: ;
                endcase
            end
        end
    end

    //************************************************************
    // Register reads
    //************************************************************

    always_comb begin
        case (reg_req_i.addr)
            fc_pkg::REG_MASK:       rdata_d = mask_q;
            fc_pkg::REG_PENDING:    rdata_d = pending_q;
            fc_pkg::REG_FIFO_HEAD:  rdata_d = fifo_empty_i ? '0 : fc_pkg::reg_data_t'(fifo_head_i);
            fc_pkg::REG_TIMER_CMP:  rdata_d = timer_cmp_q;
            fc_pkg::REG_TIMER_CTRL: rdata_d = {31'b0, timer_en_q};
            fc_pkg::REG_FETCH_EN:   rdata_d = {31'b0, fetch_en_q};
            default:                rdata_d = '0;
        endcase
    end

    // Read data comes back one cycle after the strobe
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= rdata_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_en;
        end
    end

endmodule

`default_nettype wire

// ==== src/irq_timer.sv ====
// Periodic interrupt timer, one-cycle tick every compare+1 cycles while enabled

`default_nettype none

module irq_timer (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire logic              en_i,
    input  wire fc_pkg::reg_data_t cmp_i,
    output      logic              tick_o
);

    fc_pkg::reg_data_t count_q;
    logic              match;

    // Compare against the running count
    assign match  = (count_q == cmp_i);
    assign tick_o = en_i & match;

    // Free-running counter, held at zero while disabled
    always_ff @(posedge clk_i) begin
        if (rst_i || !en_i) begin
            count_q <= '0;
        end else if (match) begin
            // Restart so the next period also starts from 0
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/event_fifo.sv ====
// SoC event identifier queue with full-not level, popped by the register read of its head

`default_nettype none

module event_fifo #(
    parameter int unsigned FIFO_DEPTH     = 4,
    parameter int unsigned EVENT_ID_WIDTH = fc_pkg::EVENT_ID_WIDTH_DEF
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire logic                      push_i,
    input  wire logic [EVENT_ID_WIDTH-1:0] push_data_i,
    input  wire logic                      pop_i,
    output      logic [EVENT_ID_WIDTH-1:0] head_o,
    output      logic                      empty_o,
    output      logic                      fulln_o
);

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

    logic [EVENT_ID_WIDTH-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr_q;
    logic [PTR_W-1:0]          rd_ptr_q;
    logic [CNT_W-1:0]          count_q;
    logic                      do_push;
    logic                      do_pop;

    assign empty_o = (count_q == '0);
    assign fulln_o = (count_q != CNT_FULL);
    assign head_o  = mem_q[rd_ptr_q];

    // Pushes beyond capacity are lost, pops on an empty queue are ignored
    assign do_push = push_i & fulln_o;
    assign do_pop  = pop_i & ~empty_o;

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/fc_pkg.sv ====
// Fabric controller event unit shared types, register map and FSM encoding

`default_nettype none

package fc_pkg;

    //************************************************************
    // Widths
    //************************************************************

    // Number of interrupt lines towards the core
    localparam int unsigned NB_IRQ_LINES = 32;

    // Default SoC event identifier width
    localparam int unsigned EVENT_ID_WIDTH_DEF = 8;

    // One bit per interrupt line
    typedef logic [NB_IRQ_LINES-1:0] irq_vec_t;

    // Interrupt line number
    typedef logic [4:0] irq_id_t;

    // SoC event identifier as held in the queue
    typedef logic [EVENT_ID_WIDTH_DEF-1:0] event_id_t;

    // Register word address and data
    typedef logic [2:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // One register access, strobe plus payload
    typedef struct packed {
        logic      valid;
        logic      write;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    //************************************************************
    // Register map
    //************************************************************

    localparam reg_addr_t REG_MASK       = 3'd0;
    localparam reg_addr_t REG_PENDING    = 3'd1;
    localparam reg_addr_t REG_CLEAR      = 3'd2;
    localparam reg_addr_t REG_FIFO_HEAD  = 3'd3;
    localparam reg_addr_t REG_TIMER_CMP  = 3'd4;
    localparam reg_addr_t REG_TIMER_CTRL = 3'd5;
    localparam reg_addr_t REG_FETCH_EN   = 3'd6;

    // Fixed line assignments
    localparam irq_id_t IRQ_TIMER_LINE = 5'd10;
    localparam irq_id_t IRQ_FIFO_LINE  = 5'd26;

    //************************************************************
    // Interrupt handshake FSM
    //************************************************************

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        CLEAR
    } irq_state_e;

endpackage

`default_nettype wire
